//--- common/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Data and address width
`define MIPS_XLEN 32

// Register file
`define MIPS_REG_AW 5
`define MIPS_NREG 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// Hazard scores, 3 means the operand is never read
`define MIPS_TIME_W 2

`endif

//--- common/mips_pkg.sv
package mips_pkg;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23
    } funct_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_or,
        alu_lui
    } alu_op_e;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_sel_e;

    typedef enum logic [1:0] {
        imm_zero,
        imm_sign,
        imm_upper
    } imm_kind_e;

    // Operand source picked by the hazard unit
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module hazard_unit import mips_pkg::*; (
    input  logic [`MIPS_REG_AW-1:0] d_rs,
    input  logic [`MIPS_REG_AW-1:0] d_rt,
    input  logic [`MIPS_TIME_W-1:0] d_t_use_rs,
    input  logic [`MIPS_TIME_W-1:0] d_t_use_rt,
    input  logic [`MIPS_REG_AW-1:0] e_rs,
    input  logic [`MIPS_REG_AW-1:0] e_rt,
    input  logic [`MIPS_REG_AW-1:0] m_rt,
    input  logic [`MIPS_REG_AW-1:0] e_dest,
    input  logic [`MIPS_REG_AW-1:0] m_dest,
    input  logic [`MIPS_REG_AW-1:0] w_dest,
    input  logic [`MIPS_TIME_W-1:0] e_t_new,
    input  logic [`MIPS_TIME_W-1:0] m_t_new,
    output logic                    stall,
    output fwd_sel_e                fwd_d_rs,
    output fwd_sel_e                fwd_d_rt,
    output fwd_sel_e                fwd_e_rs,
    output fwd_sel_e                fwd_e_rt,
    output fwd_sel_e                fwd_m_rt
);

    logic stall_rs;
    logic stall_rt;

    // Nearest ready result wins, register 0 is never forwarded
    function automatic fwd_sel_e pick(
        input logic [`MIPS_REG_AW-1:0] src,
        input logic [`MIPS_REG_AW-1:0] mem_dest,
        input logic [`MIPS_TIME_W-1:0] mem_t_new,
        input logic [`MIPS_REG_AW-1:0] wb_dest
    );
        if (src == '0)
            pick = fwd_none;
        else if (src == mem_dest && mem_t_new == '0)
            pick = fwd_mem;
        else if (src == wb_dest)
            pick = fwd_wb;
        else
            pick = fwd_none;
    endfunction

    // Scores are already aged per stage, so both stages compare against t_use
    assign stall_rs = (d_rs != '0) &&
                      ((d_rs == e_dest && e_t_new > d_t_use_rs) ||
                       (d_rs == m_dest && m_t_new > d_t_use_rs));
    assign stall_rt = (d_rt != '0) &&
                      ((d_rt == e_dest && e_t_new > d_t_use_rt) ||
                       (d_rt == m_dest && m_t_new > d_t_use_rt));
    assign stall = stall_rs || stall_rt;

    assign fwd_d_rs = pick(d_rs, m_dest, m_t_new, w_dest);
    assign fwd_d_rt = pick(d_rt, m_dest, m_t_new, w_dest);
    assign fwd_e_rs = pick(e_rs, m_dest, m_t_new, w_dest);
    assign fwd_e_rt = pick(e_rt, m_dest, m_t_new, w_dest);

    // Store data in memory can only come from writeback
    assign fwd_m_rt = (m_rt != '0 && m_rt == w_dest) ? fwd_wb : fwd_none;

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module inst_decoder import mips_pkg::*; (
    input  logic [`MIPS_XLEN-1:0]   instr,
    output logic [`MIPS_REG_AW-1:0] rs,
    output logic [`MIPS_REG_AW-1:0] rt,
    output logic [`MIPS_REG_AW-1:0] dest,
    output logic [15:0]             imm16,
    output logic [25:0]             target26,
    output alu_op_e                 alu_op,
    output imm_kind_e               imm_kind,
    output logic                    use_imm,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    is_beq,
    output logic                    is_jump,
    output wb_sel_e                 wb_sel,
    output logic [`MIPS_TIME_W-1:0] t_use_rs,
    output logic [`MIPS_TIME_W-1:0] t_use_rt,
    output logic [`MIPS_TIME_W-1:0] t_new
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode   = opcode_e'(instr[31:26]);
    assign funct    = funct_e'(instr[5:0]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign imm16    = instr[15:0];
    assign target26 = instr[25:0];

    // R-type writes rd, immediate forms write rt
    assign dest = !reg_write ? '0 : (opcode == op_special) ? instr[15:11] : rt;

    always_comb begin
        alu_op    = alu_add;
        imm_kind  = imm_sign;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        is_jump   = 1'b0;
        wb_sel    = wb_alu;
        t_use_rs  = '1;
        t_use_rt  = '1;
        t_new     = '0;
        case (opcode)
            op_special: begin
                if (funct == fn_addu || funct == fn_subu) begin
                    reg_write = 1'b1;
                    alu_op    = (funct == fn_subu) ? alu_sub : alu_add;
                    t_use_rs  = 2'd1;
                    t_use_rt  = 2'd1;
                    t_new     = 2'd1;
                end
            end
            op_ori: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_or;
                imm_kind  = imm_zero;
                t_use_rs  = 2'd1;
                t_new     = 2'd1;
            end
            op_lui: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_lui;
                imm_kind  = imm_upper;
                t_new     = 2'd1;
            end
            op_lw: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                wb_sel    = wb_mem;
                t_use_rs  = 2'd1;
                t_new     = 2'd2;
            end
            op_sw: begin
                mem_write = 1'b1;
                use_imm   = 1'b1;
                t_use_rs  = 2'd1;
                // Store data is only needed in memory
                t_use_rt  = 2'd2;
            end
            op_beq: begin
                is_beq   = 1'b1;
                t_use_rs = 2'd0;
                t_use_rt = 2'd0;
            end
            op_j: is_jump = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- design/mips_core.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MIPS_XLEN-1:0]   i_inst_rdata,
    output logic [`MIPS_XLEN-1:0]   i_inst_addr,
    input  logic [`MIPS_XLEN-1:0]   m_data_rdata,
    output logic [`MIPS_XLEN-1:0]   m_data_addr,
    output logic [`MIPS_XLEN-1:0]   m_data_wdata,
    output logic [`MIPS_XLEN-1:0]   m_inst_addr,
    output logic [3:0]              m_data_byteen,
    output logic                    w_grf_we,
    output logic [`MIPS_REG_AW-1:0] w_grf_addr,
    output logic [`MIPS_XLEN-1:0]   w_grf_wdata,
    output logic [`MIPS_XLEN-1:0]   w_inst_addr
);

    logic                    stall, redirect;
    logic [`MIPS_XLEN-1:0]   redirect_pc, d_instr, d_pc;
    logic [`MIPS_XLEN-1:0]   e_instr, e_pc, e_rs_val, e_rt_val, e_imm;
    logic [`MIPS_XLEN-1:0]   m_instr, m_pc, m_alu, m_rt_val, m_result;
    logic [`MIPS_REG_AW-1:0] d_rs, d_rt, e_rs, e_rt, m_rt, e_dest, m_dest, w_dest;
    logic [`MIPS_TIME_W-1:0] d_t_use_rs, d_t_use_rt, e_t_new, m_t_new;
    fwd_sel_e                fwd_d_rs, fwd_d_rt, fwd_e_rs, fwd_e_rt, fwd_m_rt;

    fetch_stage u_fetch (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .inst_rdata(i_inst_rdata), .inst_addr(i_inst_addr),
        .d_instr(d_instr), .d_pc(d_pc)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .stall(stall), .d_instr(d_instr), .d_pc(d_pc),
        .fwd_d_rs(fwd_d_rs), .fwd_d_rt(fwd_d_rt), .m_result(m_result),
        .w_result(w_grf_wdata), .w_we(w_grf_we), .w_addr(w_grf_addr),
        .redirect(redirect), .redirect_pc(redirect_pc), .d_rs(d_rs), .d_rt(d_rt),
        .d_t_use_rs(d_t_use_rs), .d_t_use_rt(d_t_use_rt), .e_instr(e_instr),
        .e_pc(e_pc), .e_rs_val(e_rs_val), .e_rt_val(e_rt_val), .e_imm(e_imm)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .e_instr(e_instr), .e_pc(e_pc),
        .e_rs_val(e_rs_val), .e_rt_val(e_rt_val), .e_imm(e_imm),
        .fwd_e_rs(fwd_e_rs), .fwd_e_rt(fwd_e_rt), .m_result(m_result),
        .w_result(w_grf_wdata), .e_rs(e_rs), .e_rt(e_rt), .e_dest(e_dest),
        .e_t_new(e_t_new), .m_instr(m_instr), .m_pc(m_pc), .m_alu(m_alu),
        .m_rt_val(m_rt_val)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .reset(reset), .m_instr(m_instr), .m_pc(m_pc), .m_alu(m_alu),
        .m_rt_val(m_rt_val), .fwd_m_rt(fwd_m_rt), .data_rdata(m_data_rdata),
        .data_addr(m_data_addr), .data_wdata(m_data_wdata), .data_pc(m_inst_addr),
        .data_byteen(m_data_byteen), .m_rt(m_rt), .m_dest(m_dest),
        .m_t_new(m_t_new), .m_result(m_result), .w_dest(w_dest),
        .w_we(w_grf_we), .w_addr(w_grf_addr), .w_data(w_grf_wdata), .w_pc(w_inst_addr)
    );

    hazard_unit u_hazard (
        .d_rs(d_rs), .d_rt(d_rt), .d_t_use_rs(d_t_use_rs), .d_t_use_rt(d_t_use_rt),
        .e_rs(e_rs), .e_rt(e_rt), .m_rt(m_rt), .e_dest(e_dest), .m_dest(m_dest),
        .w_dest(w_dest), .e_t_new(e_t_new), .m_t_new(m_t_new), .stall(stall),
        .fwd_d_rs(fwd_d_rs), .fwd_d_rt(fwd_d_rt), .fwd_e_rs(fwd_e_rs),
        .fwd_e_rt(fwd_e_rt), .fwd_m_rt(fwd_m_rt)
    );

endmodule

//--- pipeline/decode_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module decode_stage import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic [`MIPS_XLEN-1:0]   d_instr,
    input  logic [`MIPS_XLEN-1:0]   d_pc,
    input  fwd_sel_e                fwd_d_rs,
    input  fwd_sel_e                fwd_d_rt,
    input  logic [`MIPS_XLEN-1:0]   m_result,
    input  logic [`MIPS_XLEN-1:0]   w_result,
    input  logic                    w_we,
    input  logic [`MIPS_REG_AW-1:0] w_addr,
    output logic                    redirect,
    output logic [`MIPS_XLEN-1:0]   redirect_pc,
    output logic [`MIPS_REG_AW-1:0] d_rs,
    output logic [`MIPS_REG_AW-1:0] d_rt,
    output logic [`MIPS_TIME_W-1:0] d_t_use_rs,
    output logic [`MIPS_TIME_W-1:0] d_t_use_rt,
    output logic [`MIPS_XLEN-1:0]   e_instr,
    output logic [`MIPS_XLEN-1:0]   e_pc,
    output logic [`MIPS_XLEN-1:0]   e_rs_val,
    output logic [`MIPS_XLEN-1:0]   e_rt_val,
    output logic [`MIPS_XLEN-1:0]   e_imm
);

    logic [15:0]           imm16;
    logic [25:0]           target26;
    imm_kind_e             imm_kind;
    logic                  is_beq;
    logic                  is_jump;
    logic [`MIPS_XLEN-1:0] regs [1:`MIPS_NREG-1];
    logic [`MIPS_XLEN-1:0] rf_rs, rf_rt, rs_val, rt_val, imm_ext, pc_plus4;

    inst_decoder dec (
        .instr(d_instr), .rs(d_rs), .rt(d_rt), .dest(), .imm16(imm16),
        .target26(target26), .alu_op(), .imm_kind(imm_kind), .use_imm(),
        .reg_write(), .mem_write(), .is_beq(is_beq), .is_jump(is_jump), .wb_sel(),
        .t_use_rs(d_t_use_rs), .t_use_rt(d_t_use_rt), .t_new()
    );

    // Architectural registers start at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `MIPS_NREG; i++)
                regs[i] <= '0;
        end else if (w_we && w_addr != '0) begin
            regs[w_addr] <= w_result;
        end
    end

    assign rf_rs = (d_rs == '0) ? '0 : regs[d_rs];
    assign rf_rt = (d_rt == '0) ? '0 : regs[d_rt];

    assign rs_val = (fwd_d_rs == fwd_mem) ? m_result : (fwd_d_rs == fwd_wb) ? w_result : rf_rs;
    assign rt_val = (fwd_d_rt == fwd_mem) ? m_result : (fwd_d_rt == fwd_wb) ? w_result : rf_rt;

    always_comb begin
        case (imm_kind)
            imm_zero:  imm_ext = {16'b0, imm16};
            imm_upper: imm_ext = {imm16, 16'b0};
            default:   imm_ext = {{16{imm16[15]}}, imm16};
        endcase
    end

    assign pc_plus4    = d_pc + 32'd4;
    assign redirect    = is_jump || (is_beq && rs_val == rt_val);
    assign redirect_pc = is_jump ? {pc_plus4[31:28], target26, 2'b00}
                                 : pc_plus4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset || stall)
            e_instr <= '0;
        else
            e_instr <= d_instr;
    end

    always_ff @(posedge clk) begin
        e_pc     <= d_pc;
        e_rs_val <= rs_val;
        e_rt_val <= rt_val;
        e_imm    <= imm_ext;
    end

endmodule

//--- pipeline/execute_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module execute_stage import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MIPS_XLEN-1:0]   e_instr,
    input  logic [`MIPS_XLEN-1:0]   e_pc,
    input  logic [`MIPS_XLEN-1:0]   e_rs_val,
    input  logic [`MIPS_XLEN-1:0]   e_rt_val,
    input  logic [`MIPS_XLEN-1:0]   e_imm,
    input  fwd_sel_e                fwd_e_rs,
    input  fwd_sel_e                fwd_e_rt,
    input  logic [`MIPS_XLEN-1:0]   m_result,
    input  logic [`MIPS_XLEN-1:0]   w_result,
    output logic [`MIPS_REG_AW-1:0] e_rs,
    output logic [`MIPS_REG_AW-1:0] e_rt,
    output logic [`MIPS_REG_AW-1:0] e_dest,
    output logic [`MIPS_TIME_W-1:0] e_t_new,
    output logic [`MIPS_XLEN-1:0]   m_instr,
    output logic [`MIPS_XLEN-1:0]   m_pc,
    output logic [`MIPS_XLEN-1:0]   m_alu,
    output logic [`MIPS_XLEN-1:0]   m_rt_val
);

    alu_op_e               alu_op;
    logic                  use_imm;
    logic [`MIPS_XLEN-1:0] a, b_reg, b, result;

    inst_decoder dec (
        .instr(e_instr), .rs(e_rs), .rt(e_rt), .dest(e_dest), .imm16(),
        .target26(), .alu_op(alu_op), .imm_kind(), .use_imm(use_imm),
        .reg_write(), .mem_write(), .is_beq(), .is_jump(), .wb_sel(),
        .t_use_rs(), .t_use_rt(), .t_new(e_t_new)
    );

    assign a     = (fwd_e_rs == fwd_mem) ? m_result : (fwd_e_rs == fwd_wb) ? w_result : e_rs_val;
    assign b_reg = (fwd_e_rt == fwd_mem) ? m_result : (fwd_e_rt == fwd_wb) ? w_result : e_rt_val;
    assign b     = use_imm ? e_imm : b_reg;

    always_comb begin
        case (alu_op)
            alu_sub: result = a - b;
            alu_or:  result = a | b;
            // Immediate arrives already shifted up
            alu_lui: result = b;
            default: result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            m_instr <= '0;
        else
            m_instr <= e_instr;
    end

    always_ff @(posedge clk) begin
        m_pc     <= e_pc;
        m_alu    <= result;
        m_rt_val <= b_reg;
    end

endmodule

//--- pipeline/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [`MIPS_XLEN-1:0] redirect_pc,
    input  logic [`MIPS_XLEN-1:0] inst_rdata,
    output logic [`MIPS_XLEN-1:0] inst_addr,
    output logic [`MIPS_XLEN-1:0] d_instr,
    output logic [`MIPS_XLEN-1:0] d_pc
);

    logic [`MIPS_XLEN-1:0] pc;

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `MIPS_RESET_PC;
            d_instr <= '0;
        end else if (!stall) begin
            // Redirect lands after the delay slot already fetched
            pc      <= redirect ? redirect_pc : pc + 32'd4;
            d_instr <= inst_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            d_pc <= pc;
    end

endmodule

//--- pipeline/mem_wb_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mem_wb_stage import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MIPS_XLEN-1:0]   m_instr,
    input  logic [`MIPS_XLEN-1:0]   m_pc,
    input  logic [`MIPS_XLEN-1:0]   m_alu,
    input  logic [`MIPS_XLEN-1:0]   m_rt_val,
    input  fwd_sel_e                fwd_m_rt,
    input  logic [`MIPS_XLEN-1:0]   data_rdata,
    output logic [`MIPS_XLEN-1:0]   data_addr,
    output logic [`MIPS_XLEN-1:0]   data_wdata,
    output logic [`MIPS_XLEN-1:0]   data_pc,
    output logic [3:0]              data_byteen,
    output logic [`MIPS_REG_AW-1:0] m_rt,
    output logic [`MIPS_REG_AW-1:0] m_dest,
    output logic [`MIPS_TIME_W-1:0] m_t_new,
    output logic [`MIPS_XLEN-1:0]   m_result,
    output logic [`MIPS_REG_AW-1:0] w_dest,
    output logic                    w_we,
    output logic [`MIPS_REG_AW-1:0] w_addr,
    output logic [`MIPS_XLEN-1:0]   w_data,
    output logic [`MIPS_XLEN-1:0]   w_pc
);

    logic                  mem_write;
    logic [`MIPS_TIME_W-1:0] e_score;
    logic [`MIPS_XLEN-1:0] w_instr, w_alu, w_mem;
    wb_sel_e               wb_sel;

    inst_decoder dec_m (
        .instr(m_instr), .rs(), .rt(m_rt), .dest(m_dest), .imm16(),
        .target26(), .alu_op(), .imm_kind(), .use_imm(),
        .reg_write(), .mem_write(mem_write), .is_beq(), .is_jump(), .wb_sel(),
        .t_use_rs(), .t_use_rt(), .t_new(e_score)
    );

    // Decoder gives the score at execute; one stage later it is one less
    assign m_t_new  = (e_score == '0) ? '0 : e_score - 1'b1;
    assign m_result = m_alu;

    assign data_addr   = m_alu;
    assign data_wdata  = (fwd_m_rt == fwd_wb) ? w_data : m_rt_val;
    assign data_pc     = m_pc;
    assign data_byteen = mem_write ? 4'b1111 : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset)
            w_instr <= '0;
        else
            w_instr <= m_instr;
    end

    always_ff @(posedge clk) begin
        w_pc  <= m_pc;
        w_alu <= m_alu;
        w_mem <= data_rdata;
    end

    inst_decoder dec_w (
        .instr(w_instr), .rs(), .rt(), .dest(w_dest), .imm16(),
        .target26(), .alu_op(), .imm_kind(), .use_imm(),
        .reg_write(w_we), .mem_write(), .is_beq(), .is_jump(), .wb_sel(wb_sel),
        .t_use_rs(), .t_use_rt(), .t_new()
    );

    assign w_addr = w_dest;
    assign w_data = (wb_sel == wb_mem) ? w_mem : w_alu;

endmodule

//--- src.f
+incdir+common
common/mips_pkg.sv
design/inst_decoder.sv
design/hazard_unit.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/mem_wb_stage.sv
design/mips_core.sv
test/clock_gen.sv
test/mips_tb.sv

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Released on a falling edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- test/mips_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_tb import mips_pkg::*; ();

    localparam int n_rounds     = 4;
    localparam int rom_words    = 128;
    localparam int reset_cycles = 16;

    logic                    clk, reset;
    logic [`MIPS_XLEN-1:0]   i_inst_rdata, i_inst_addr;
    logic [`MIPS_XLEN-1:0]   m_data_rdata, m_data_addr, m_data_wdata, m_inst_addr;
    logic [3:0]              m_data_byteen;
    logic                    w_grf_we;
    logic [`MIPS_REG_AW-1:0] w_grf_addr;
    logic [`MIPS_XLEN-1:0]   w_grf_wdata, w_inst_addr;

    logic [31:0] imem [rom_words];
    logic [31:0] dmem [64];
    logic [31:0] model_mem [64];
    logic [31:0] model_regs [32];
    logic [31:0] lfsr_state, end_pc;
    int          prog_len, exec_count, value_errors, other_errors;
    logic        model_done, was_reset;
    logic [31:0] exp_wr_pc [$];
    logic [31:0] exp_wr_data [$];
    logic [4:0]  exp_wr_addr [$];
    logic [31:0] exp_st_pc [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    clock_gen #(.half_period(4), .reset_cycles(reset_cycles)) clocks (
        .clk(clk), .reset(reset)
    );

    mips_core UUT (
        .clk(clk), .reset(reset), .i_inst_rdata(i_inst_rdata), .i_inst_addr(i_inst_addr),
        .m_data_rdata(m_data_rdata), .m_data_addr(m_data_addr),
        .m_data_wdata(m_data_wdata), .m_inst_addr(m_inst_addr),
        .m_data_byteen(m_data_byteen), .w_grf_we(w_grf_we), .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input funct_e fn);
        return {op_special, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `MIPS_RESET_PC) >> 2;
        return (idx < rom_words) ? imem[idx] : 32'h0;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [4:0]  ra, rb, rc, rd, rdat, re, rf;
        logic [15:0] base;
        for (int k = 0; k < n_rounds; k++) begin
            ra   = 5'(1 + take_bits(1));
            rb   = 5'(3 + take_bits(1));
            rc   = 5'(5 + take_bits(1));
            rd   = 5'(7 + take_bits(1));
            rdat = 5'(10 + take_bits(1));
            re   = 5'(12 + take_bits(1));
            rf   = 5'(14 + take_bits(1));
            base = 16'(take_bits(6) << 2);
            // Dependent ALU chain, ra is never zero
            emit(enc_i(op_lui, 5'd0, ra, 16'(take_bits(16)) | 16'h1));
            emit(enc_i(op_ori, ra, ra, 16'(take_bits(16))));
            emit(enc_r(ra, rc, rb, fn_addu));
            emit(enc_r(rb, ra, rc, fn_subu));
            emit(enc_i(op_ori, rb, 5'd0, 16'(take_bits(16))));
            emit(enc_r(5'd0, rc, rd, fn_addu));
            // Store of a fresh value, then load-use
            emit(enc_i(op_ori, 5'd0, 5'd9, base));
            emit(enc_r(rc, rb, rdat, fn_addu));
            emit(enc_i(op_sw, 5'd9, rdat, 16'h0));
            emit(enc_i(op_lw, 5'd9, re, 16'h0));
            emit(enc_r(re, rd, rf, fn_addu));
            // Taken beq, untaken beq, then j, each with a delay slot
            emit(enc_i(op_beq, rf, rf, 16'd2));
            emit(enc_i(op_ori, 5'd0, rf, 16'(take_bits(16))));
            emit(enc_i(op_lui, 5'd0, rf, 16'hdead));
            emit(enc_i(op_beq, ra, 5'd0, 16'd5));
            emit(enc_r(rf, rb, rc, fn_subu));
            emit({op_j, 26'((`MIPS_RESET_PC + 4 * (prog_len + 3)) >> 2)});
            emit(enc_r(rc, rf, ra, fn_addu));
            emit(enc_i(op_ori, 5'd0, ra, 16'hbeef));
        end
        end_pc = `MIPS_RESET_PC + 4 * prog_len;
        emit({op_j, 26'(end_pc >> 2)});
        emit(32'h0);
    endtask

    task automatic note_write(input logic [31:0] pc, input logic [4:0] addr,
                              input logic [31:0] data);
        exp_wr_pc.push_back(pc);
        exp_wr_addr.push_back(addr);
        exp_wr_data.push_back(data);
        if (addr != 5'd0)
            model_regs[addr] = data;
    endtask

    // Sequential ISA model with one delay slot after every branch or jump
    task automatic run_model();
        logic [31:0] pc, npc, cur, ir, a, b, sext, addr;
        pc = `MIPS_RESET_PC;
        npc = pc + 32'd4;
        exec_count = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        while (pc != end_pc && exec_count < 1000) begin
            cur  = pc;
            ir   = fetch_word(cur);
            a    = model_regs[ir[25:21]];
            b    = model_regs[ir[20:16]];
            sext = {{16{ir[15]}}, ir[15:0]};
            addr = a + sext;
            pc   = npc;
            npc  = npc + 32'd4;
            exec_count++;
            case (ir[31:26])
                op_special:
                    if (ir[5:0] == fn_addu || ir[5:0] == fn_subu)
                        note_write(cur, ir[15:11], (ir[5:0] == fn_subu) ? a - b : a + b);
                op_ori: note_write(cur, ir[20:16], a | {16'h0, ir[15:0]});
                op_lui: note_write(cur, ir[20:16], {ir[15:0], 16'h0});
                op_lw:  note_write(cur, ir[20:16], model_mem[addr[7:2]]);
                op_sw: begin
                    model_mem[addr[7:2]] = b;
                    exp_st_pc.push_back(cur);
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                op_beq: if (a == b) npc = cur + 32'd4 + (sext << 2);
                op_j:   npc = {pc[31:28], ir[25:0], 2'b00};
                default: ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            value_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        i_inst_rdata <= fetch_word(i_inst_addr);
        m_data_rdata <= dmem[m_data_addr[7:2]];
    end

    always @(posedge clk) begin
        was_reset <= reset;
        if (!reset) begin
            if (was_reset) begin
                check_value("i_inst_addr", i_inst_addr, `MIPS_RESET_PC);
                check_value("w_grf_we", {31'h0, w_grf_we}, 32'h0);
                check_value("m_data_byteen", {28'h0, m_data_byteen}, 32'h0);
            end
            if (w_grf_we) begin
                if (exp_wr_pc.size() == 0) begin
                    other_errors++;
                    $display("Register write from pc %h was not expected", w_inst_addr);
                end else begin
                    check_value("w_inst_addr", w_inst_addr, exp_wr_pc.pop_front());
                    check_value("w_grf_addr", {27'h0, w_grf_addr},
                                {27'h0, exp_wr_addr.pop_front()});
                    check_value("w_grf_wdata", w_grf_wdata, exp_wr_data.pop_front());
                end
            end
            if (m_data_byteen != 4'h0) begin
                if (exp_st_addr.size() == 0) begin
                    other_errors++;
                    $display("Store from pc %h was not expected", m_inst_addr);
                end else begin
                    check_value("m_data_byteen", {28'h0, m_data_byteen}, 32'hf);
                    check_value("m_inst_addr", m_inst_addr, exp_st_pc.pop_front());
                    check_value("m_data_addr", m_data_addr, exp_st_addr.pop_front());
                    check_value("m_data_wdata", m_data_wdata, exp_st_data.pop_front());
                end
            end
            if (m_data_byteen == 4'hf)
                dmem[m_data_addr[7:2]] <= m_data_wdata;
        end
    end

    initial begin
        i_inst_rdata = '0;
        m_data_rdata = '0;
        value_errors = 0;
        other_errors = 0;
        model_done   = 1'b0;
        was_reset    = 1'b0;
        lfsr_state   = 32'he068b17b;
        prog_len     = 0;
        for (int i = 0; i < rom_words; i++)
            imem[i] = '0;
        // Fill value mixes the full byte address
        for (int i = 0; i < 64; i++) begin
            dmem[i] = ((32'(i) << 2) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
            model_mem[i] = dmem[i];
        end
        build_program();
        run_model();
        model_done = 1'b1;
        while (exp_wr_pc.size() != 0 || exp_st_addr.size() != 0)
            @(posedge clk);
        // Idle cycles catch writes past the end of the program
        repeat (20) @(posedge clk);
        $display("Error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        wait (model_done);
        repeat (reset_cycles + 3 * exec_count + 50) @(posedge clk);
        other_errors++;
        $display("Timeout: the core did not retire the whole program in time");
        $display("Error counts: %0d value, %0d other", value_errors, other_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule
